// ==== volley_settings.svh ====
`ifndef VOLLEY_SETTINGS_SVH
`define VOLLEY_SETTINGS_SVH

// ----------------------------------------------------------
// court geometry in screen pixels
// ----------------------------------------------------------
`define NET_X          512    // net position, the ground left of it is player 1's half
`define GROUND_Y       750    // ball lower edge at or below this touches the ground
`define BALL_R         12     // ball half size
`define PLAYER_Y       640    // top edge of both players
`define PLAYER_W       40     // player half width

// ----------------------------------------------------------
// rules of the rally
// ----------------------------------------------------------
`define TOUCH_LIMIT    4      // this many consecutive touches is a fault
`define HOLDOFF_CYCLES 16     // contacts ignored for this long after a counted touch
`define WIN_SCORE      15     // first player to this score ends the game

`endif

// ==== volley_geom_pkg.sv ====
package volley_geom_pkg;

   // ----------------------------------------------------------
   // screen coordinates
   // ----------------------------------------------------------
   localparam int COORD_W = 12;

   typedef logic [COORD_W-1:0] coord_t;   // one pixel coordinate, x or y

   // ball center as sampled from the physics side
   typedef struct packed {
      coord_t x;
      coord_t y;   // grows downward toward the ground
   } ball_pos_t;

endpackage

// ==== volley_game_pkg.sv ====
package volley_game_pkg;

   // ----------------------------------------------------------
   // score keeping
   // ----------------------------------------------------------
   typedef logic [3:0] score_t;       // holds up to the winning score
   typedef logic [2:0] touch_cnt_t;   // consecutive touches of one player

   typedef enum logic {
      player_1,
      player_2
   } player_t;

   typedef enum logic [1:0] {
      serve_wait,    // waiting for the first touch of a rally
      rally,
      point_award,
      game_over
   } judge_state_t;

   // ----------------------------------------------------------
   // contact events from the detector to the judge
   // ----------------------------------------------------------
   typedef struct packed {
      logic p1_hit;           // single cycle pulses
      logic p2_hit;
      logic ground;
      logic landed_p2_side;   // only valid together with ground
   } contact_t;

endpackage

// ==== contact_detect.sv ====
`include "volley_settings.svh"

module contact_detect
   import volley_geom_pkg::*;
   import volley_game_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  ball_pos_t ball_pos,
   input  coord_t    player1_x,
   input  coord_t    player2_x,
   output contact_t  contact
);

   // one extra bit so the box edges never wrap around
   localparam int XW = $bits(coord_t) + 1;

   localparam logic [XW-1:0] REACH_X   = XW'(`BALL_R + `PLAYER_W);
   localparam logic [XW-1:0] BALL_HALF = XW'(`BALL_R);
   localparam logic [XW-1:0] TOP_Y     = XW'(`PLAYER_Y);
   localparam logic [XW-1:0] BOTTOM_Y  = XW'(`GROUND_Y + `BALL_R);
   localparam logic [XW-1:0] FLOOR_Y   = XW'(`GROUND_Y);
   localparam coord_t        NET       = coord_t'(`NET_X);

   // bit 0 player 1, bit 1 player 2, bit 2 ground
   logic [2:0] lvl;
   logic [2:0] lvl_prev;
   logic [2:0] rise;
   logic [2:0] pulse;
   logic       side_p2;

   // ----------------------------------------------------------
   // geometric tests on the current sample
   // ----------------------------------------------------------

   // ball box against a player box reaching from PLAYER_Y to the ground
   function automatic logic player_overlap(input ball_pos_t b, input coord_t px);
      logic [XW-1:0] bx;
      logic [XW-1:0] by;
      logic [XW-1:0] pxw;
      logic          x_hit;
      logic          y_hit;
      bx    = XW'(b.x);
      by    = XW'(b.y);
      pxw   = XW'(px);
      x_hit = (bx + REACH_X >= pxw) && (pxw + REACH_X >= bx);
      y_hit = (by + BALL_HALF >= TOP_Y) && (by <= BOTTOM_Y);
      return x_hit && y_hit;
   endfunction

   always_comb begin
      lvl[0] = player_overlap(ball_pos, player1_x);
      lvl[1] = player_overlap(ball_pos, player2_x);
      lvl[2] = (XW'(ball_pos.y) + BALL_HALF >= FLOOR_Y);   // lower edge at the ground
   end

   assign rise = lvl & ~lvl_prev;

   // ----------------------------------------------------------
   // edge detection into registered pulses
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         lvl_prev <= '0;
         pulse    <= '0;
      end else begin
         lvl_prev <= lvl;
         pulse    <= rise;   // high for one cycle on the first true sample
      end
   end

   // landing side is captured with the ground edge and held until the next one
   always_ff @(posedge clk) begin
      if (rise[2]) begin
         side_p2 <= (ball_pos.x >= NET);
      end
   end

   assign contact = '{
      p1_hit:         pulse[0],
      p2_hit:         pulse[1],
      ground:         pulse[2],
      landed_p2_side: side_p2
   };

endmodule

// ==== volley_judge.sv ====
`include "volley_settings.svh"

module volley_judge
   import volley_game_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  contact_t contact,
   output score_t   score_p1,
   output score_t   score_p2,
   output logic     point,
   output player_t  point_winner,
   output logic     third_touch,
   output logic     game_over
);

   localparam int                HOLD_W    = $clog2(`HOLDOFF_CYCLES + 1);
   localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(`HOLDOFF_CYCLES);
   localparam touch_cnt_t        TOUCH_MAX = touch_cnt_t'(`TOUCH_LIMIT);
   localparam score_t            SCORE_WIN = score_t'(`WIN_SCORE);

   judge_state_t      state;
   judge_state_t      state_nxt;
   touch_cnt_t        touch_p1;
   touch_cnt_t        touch_p1_nxt;
   touch_cnt_t        touch_p2;
   touch_cnt_t        touch_p2_nxt;
   logic [HOLD_W-1:0] hold_cnt;
   logic [HOLD_W-1:0] hold_nxt;
   logic              hold_idle;
   player_t           winner_pend;
   player_t           winner_nxt;
   score_t            score_p1_nxt;
   score_t            score_p2_nxt;
   logic              point_nxt;
   player_t           point_winner_nxt;
   logic              third_nxt;
   logic              game_over_nxt;

   assign hold_idle = (hold_cnt == '0);

   // ----------------------------------------------------------
   // state and control registers
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= serve_wait;
         touch_p1    <= '0;
         touch_p2    <= '0;
         hold_cnt    <= '0;
         score_p1    <= '0;
         score_p2    <= '0;
         point       <= 1'b0;
         third_touch <= 1'b0;
         game_over   <= 1'b0;
      end else begin
         state       <= state_nxt;
         touch_p1    <= touch_p1_nxt;
         touch_p2    <= touch_p2_nxt;
         hold_cnt    <= hold_nxt;
         score_p1    <= score_p1_nxt;
         score_p2    <= score_p2_nxt;
         point       <= point_nxt;
         third_touch <= third_nxt;
         game_over   <= game_over_nxt;
      end
   end

   always_ff @(posedge clk) begin
      winner_pend  <= winner_nxt;
      point_winner <= point_winner_nxt;   // only looked at while point is high
   end

   // ----------------------------------------------------------
   // rally rules
   // ----------------------------------------------------------
   always_comb begin
      state_nxt        = state;
      touch_p1_nxt     = touch_p1;
      touch_p2_nxt     = touch_p2;
      hold_nxt         = hold_idle ? hold_cnt : hold_cnt - 1'b1;
      winner_nxt       = winner_pend;
      score_p1_nxt     = score_p1;
      score_p2_nxt     = score_p2;
      point_nxt        = 1'b0;
      point_winner_nxt = point_winner;
      third_nxt        = third_touch;
      game_over_nxt    = game_over;

      case (state)
         serve_wait: begin
            // player 1 takes precedence when both touch in the same cycle
            if (contact.p1_hit) begin
               touch_p1_nxt = touch_cnt_t'(1);
               touch_p2_nxt = '0;
               hold_nxt     = HOLD_LOAD;
               state_nxt    = rally;
            end else if (contact.p2_hit) begin
               touch_p1_nxt = '0;
               touch_p2_nxt = touch_cnt_t'(1);
               hold_nxt     = HOLD_LOAD;
               state_nxt    = rally;
            end
         end

         rally: begin
            if (contact.ground) begin   // a landing beats a touch in the same cycle
               winner_nxt = contact.landed_p2_side ? player_1 : player_2;
               state_nxt  = point_award;
            end else if (hold_idle && (contact.p1_hit || contact.p2_hit)) begin
               hold_nxt = HOLD_LOAD;
               if (contact.p1_hit) begin
                  touch_p1_nxt = touch_p1 + 1'b1;
                  touch_p2_nxt = '0;
               end else begin
                  touch_p1_nxt = '0;
                  touch_p2_nxt = touch_p2 + 1'b1;
               end
               // too many touches hands the point to the other side
               if (touch_p1_nxt == TOUCH_MAX) begin
                  winner_nxt = player_2;
                  third_nxt  = 1'b1;
                  state_nxt  = point_award;
               end else if (touch_p2_nxt == TOUCH_MAX) begin
                  winner_nxt = player_1;
                  third_nxt  = 1'b1;
                  state_nxt  = point_award;
               end
            end
         end

         point_award: begin
            point_nxt        = 1'b1;
            point_winner_nxt = winner_pend;
            touch_p1_nxt     = '0;
            touch_p2_nxt     = '0;
            if (winner_pend == player_1) begin
               score_p1_nxt = score_p1 + 1'b1;
            end else begin
               score_p2_nxt = score_p2 + 1'b1;
            end
            if (score_p1_nxt == SCORE_WIN || score_p2_nxt == SCORE_WIN) begin
               state_nxt     = volley_game_pkg::game_over;
               game_over_nxt = 1'b1;
            end else begin
               state_nxt = serve_wait;
               third_nxt = 1'b0;   // the fault flag lasts until the next serve
            end
         end

         volley_game_pkg::game_over: begin
            game_over_nxt = 1'b1;   // frozen until reset
         end

         default: begin
            state_nxt = serve_wait;
         end
      endcase
   end

endmodule

// ==== volley_referee_top.sv ====
module volley_referee_top
   import volley_geom_pkg::*;
   import volley_game_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  ball_pos_t ball_pos,
   input  coord_t    player1_x,
   input  coord_t    player2_x,
   output score_t    score_p1,
   output score_t    score_p2,
   output logic      point,
   output player_t   point_winner,
   output logic      third_touch,
   output logic      game_over
);

   contact_t contact;   // single cycle events into the judge

   // ----------------------------------------------------------
   // positions to contact events
   // ----------------------------------------------------------
   contact_detect contact_detect_inst (
      .clk       (clk),
      .rst       (rst),
      .ball_pos  (ball_pos),
      .player1_x (player1_x),
      .player2_x (player2_x),
      .contact   (contact)
   );

   // ----------------------------------------------------------
   // rally rules and scoring
   // ----------------------------------------------------------
   volley_judge volley_judge_inst (
      .clk          (clk),
      .rst          (rst),
      .contact      (contact),
      .score_p1     (score_p1),
      .score_p2     (score_p2),
      .point        (point),
      .point_winner (point_winner),
      .third_touch  (third_touch),
      .game_over    (game_over)
   );

endmodule

// ==== tb_volley_checker.sv ====
`include "volley_settings.svh"

module tb_volley_checker
   import volley_geom_pkg::*;
   import volley_game_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  ball_pos_t ball_pos,
   input  coord_t    player1_x,
   input  coord_t    player2_x,
   input  score_t    score_p1,
   input  score_t    score_p2,
   input  logic      point,
   input  player_t   point_winner,
   input  logic      third_touch,
   input  logic      game_over,
   input  int        test_num,
   input  logic      test_done,
   output int        errors,
   output int        checks
);

   localparam int MAX_PRINTS = 40;

   // ----------------------------------------------------------
   // reference model state, stepped once per rising edge
   // ----------------------------------------------------------
   logic [2:0]   seen;         // last levels of player 1, player 2 and ground
   logic [2:0]   hit;          // contact pulses as the judge sees them
   logic         land_p2;
   judge_state_t st;
   int           cnt1;
   int           cnt2;
   int           hold;         // cycles left in the hold-off window
   player_t      pend;
   player_t      win_exp;
   int           s1;
   int           s2;
   logic         pt_exp;
   logic         third_exp;
   logic         over_exp;
   logic         valid = 1'b0;
   int           cycle;
   int           test_base;
   int           reason;       // 0 none, 1 landing, 2 touch fault

   function automatic logic touches_player(input ball_pos_t b, input coord_t px);
      int dx;
      dx = int'(b.x) - int'(px);
      if (dx < 0) begin
         dx = -dx;
      end
      return (dx <= `BALL_R + `PLAYER_W) && (int'(b.y) + `BALL_R >= `PLAYER_Y)
             && (int'(b.y) - `BALL_R <= `GROUND_Y);   // player box runs down to the ground
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         if (errors <= MAX_PRINTS) begin
            $display("** Error cycle %0d: %s = %h, expected %h", cycle, name, got, exp);
         end
      end
   endtask

   task automatic report(input string msg);
      errors++;
      if (errors <= MAX_PRINTS) begin
         $display("cycle %0d: %s", cycle, msg);
      end
   endtask

   task automatic reset_model();
      seen      = '0;
      hit       = '0;
      land_p2   = 1'b0;
      st        = serve_wait;
      cnt1      = 0;
      cnt2      = 0;
      hold      = 0;
      pend      = player_1;
      win_exp   = player_1;
      s1        = 0;
      s2        = 0;
      pt_exp    = 1'b0;
      third_exp = 1'b0;
      over_exp  = 1'b0;
      errors    = 0;
      checks    = 0;
      cycle     = 0;
      test_base = 0;
      reason    = 0;
   endtask

   task automatic compare_outputs();
      checks++;
      if (point !== pt_exp) begin
         report(pt_exp ? "point pulse missing" : "point pulse where none was due");
      end else if (pt_exp) begin
         check_value("point_winner", 32'(point_winner), 32'(win_exp));
      end
      check_value("score_p1", 32'(score_p1), s1);
      check_value("score_p2", 32'(score_p2), s2);
      check_value("third_touch", 32'(third_touch), 32'(third_exp));
      check_value("game_over", 32'(game_over), 32'(over_exp));
   endtask

   // ----------------------------------------------------------
   // judge rules
   // ----------------------------------------------------------
   task automatic step_judge();
      logic idle;
      idle   = (hold == 0);
      hold   = idle ? 0 : hold - 1;
      pt_exp = 1'b0;
      case (st)
         serve_wait: begin
            if (hit[0] || hit[1]) begin   // the serve is a first touch
               cnt1 = hit[0] ? 1 : 0;
               cnt2 = hit[0] ? 0 : 1;
               hold = `HOLDOFF_CYCLES;
               st   = rally;
            end
         end
         rally: begin
            if (hit[2]) begin
               pend   = land_p2 ? player_1 : player_2;
               reason = 1;
               st     = point_award;
            end else if (idle && (hit[0] || hit[1])) begin
               hold = `HOLDOFF_CYCLES;
               cnt1 = hit[0] ? cnt1 + 1 : 0;
               cnt2 = hit[0] ? 0 : cnt2 + 1;
               if (cnt1 >= `TOUCH_LIMIT || cnt2 >= `TOUCH_LIMIT) begin
                  pend      = (cnt1 >= `TOUCH_LIMIT) ? player_2 : player_1;
                  third_exp = 1'b1;
                  reason    = 2;
                  st        = point_award;
               end
            end
         end
         point_award: begin
            pt_exp  = 1'b1;
            win_exp = pend;
            cnt1    = 0;
            cnt2    = 0;
            if (pend == player_1) begin
               s1++;
            end else begin
               s2++;
            end
            if (s1 >= `WIN_SCORE || s2 >= `WIN_SCORE) begin
               over_exp = 1'b1;
               st       = volley_game_pkg::game_over;
            end else begin
               third_exp = 1'b0;
               st        = serve_wait;
            end
         end
         default: begin
         end
      endcase
   endtask

   // detector with its one cycle of latency
   task automatic step_detect();
      logic [2:0] now;
      now[0] = touches_player(ball_pos, player1_x);
      now[1] = touches_player(ball_pos, player2_x);
      now[2] = (int'(ball_pos.y) + `BALL_R >= `GROUND_Y);
      hit    = now & ~seen;
      if (hit[2]) begin
         land_p2 = (int'(ball_pos.x) >= `NET_X);
      end
      seen = now;
   endtask

   task automatic end_test();
      string what;
      string result;
      if (reason == 1) begin
         what = $sformatf("landing, point to player %0d", (win_exp == player_1) ? 1 : 2);
      end else if (reason == 2) begin
         what = $sformatf("touch fault, point to player %0d", (win_exp == player_1) ? 1 : 2);
      end else if (test_num == 0) begin
         what = "reset state";
      end else begin
         what = "no point, game is over";
      end
      if (errors == test_base) begin
         result = "ok";
      end else begin
         result = $sformatf("%0d errors", errors - test_base);
      end
      $display("test %0d %s: %s", test_num, what, result);
      test_base = errors;
      reason    = 0;
   endtask

   always @(posedge clk) begin
      if (rst) begin
         reset_model();
         valid = 1'b1;
      end else if (valid) begin
         cycle++;
         compare_outputs();   // outputs still hold the values of the last edge
         if (test_done) begin
            end_test();
         end
         step_judge();
         step_detect();
      end
   end

endmodule

// ==== tb_volley_referee.sv ====
`include "volley_settings.svh"

module tb_volley_referee
   import volley_geom_pkg::*;
   import volley_game_pkg::*;
();

   localparam int     N_RALLIES   = 34;   // a full game needs at most 29 points
   localparam int     POINT_WAIT  = 8;
   localparam int     RALLY_MAX   = 3 * 4 * (2 + `HOLDOFF_CYCLES + 6) + POINT_WAIT + 12;
   localparam int     CYCLE_LIMIT = 8 + N_RALLIES * (RALLY_MAX + 2) + 100;
   localparam coord_t AIR_Y       = coord_t'(200);

   logic        clk;
   logic        rst;
   ball_pos_t   ball_pos;
   coord_t      player1_x;
   coord_t      player2_x;
   score_t      score_p1;
   score_t      score_p2;
   logic        point;
   player_t     point_winner;
   logic        third_touch;
   logic        game_over;
   int          test_num;
   logic        test_done;
   int          chk_errors;
   int          chk_checks;
   int          tb_errors;
   int          cycles;
   int          total;
   int          point_count = 0;
   logic [31:0] lfsr;

   volley_referee_top volley_referee_top_inst (
      .clk          (clk),
      .rst          (rst),
      .ball_pos     (ball_pos),
      .player1_x    (player1_x),
      .player2_x    (player2_x),
      .score_p1     (score_p1),
      .score_p2     (score_p2),
      .point        (point),
      .point_winner (point_winner),
      .third_touch  (third_touch),
      .game_over    (game_over)
   );

   tb_volley_checker checker_inst (
      .clk          (clk),
      .rst          (rst),
      .ball_pos     (ball_pos),
      .player1_x    (player1_x),
      .player2_x    (player2_x),
      .score_p1     (score_p1),
      .score_p2     (score_p2),
      .point        (point),
      .point_winner (point_winner),
      .third_touch  (third_touch),
      .game_over    (game_over),
      .test_num     (test_num),
      .test_done    (test_done),
      .errors       (chk_errors),
      .checks       (chk_checks)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      if (point) begin
         point_count <= point_count + 1;
      end
   end

   // ----------------------------------------------------------
   // random bits and stimulus
   // ----------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output int v);
      v = 0;
      repeat (n) begin
         lfsr = lfsr_next(lfsr);
         v    = v * 2 + (lfsr[0] ? 1 : 0);
      end
   endtask

   // ball on the player for 2 cycles, then gap cycles in the air
   task automatic touch_ball(input player_t who, input int gap);
      @(negedge clk);
      ball_pos.x = (who == player_1) ? player1_x : player2_x;
      ball_pos.y = coord_t'(`PLAYER_Y);
      repeat (2) @(negedge clk);
      ball_pos.y = AIR_Y;
      repeat (gap - 1) @(negedge clk);
   endtask

   task automatic land_ball(input coord_t x);
      @(negedge clk);
      ball_pos.x = x;
      ball_pos.y = coord_t'(`GROUND_Y);
      repeat (2) @(negedge clk);
      ball_pos.y = AIR_Y;
   endtask

   task automatic wait_point(input int r, input int start);
      int n;
      n = 0;
      while (point_count == start && !game_over && n < POINT_WAIT) begin
         @(negedge clk);
         n++;
      end
      if (point_count == start && !game_over) begin
         $display("rally %0d ended without a point pulse", r);
         tb_errors++;
      end
   endtask

   task automatic run_rally(input int r);
      int   start;
      int   nseg;
      int   ntouch;
      int   who;
      int   long_gap;
      int   g;
      int   v;
      int   s;
      int   t;
      logic ended;
      start = point_count;
      ended = 1'b0;
      @(negedge clk);
      take_bits(8, v);
      player1_x = coord_t'(60 + v);
      take_bits(8, v);
      player2_x = coord_t'(620 + v);
      take_bits(2, v);
      nseg = 1 + v % 3;
      for (s = 0; s < nseg && !ended; s++) begin
         take_bits(1, who);
         take_bits(2, v);
         ntouch = v + 1;
         for (t = 0; t < ntouch && !ended; t++) begin
            take_bits(1, long_gap);
            take_bits(3, g);
            // touch spacing reaches the last ignored and the first counted cycle
            g = long_gap != 0 ? `HOLDOFF_CYCLES - 1 + g : `HOLDOFF_CYCLES - 9 + g;
            touch_ball(who != 0 ? player_2 : player_1, g);
            ended = (point_count != start);   // a touch fault already ended it
         end
      end
      if (!ended) begin
         take_bits(10, v);
         land_ball(coord_t'(20 + v));
      end
      wait_point(r, start);
      repeat (3) @(negedge clk);
   endtask

   task automatic end_test(input int n);
      @(negedge clk);
      test_num  = n;
      test_done = 1'b1;
      @(negedge clk);
      test_done = 1'b0;
   endtask

   // ----------------------------------------------------------
   // run limit
   // ----------------------------------------------------------
   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
   end

   initial begin
      lfsr      = 32'h0578d2db;
      rst       = 1'b1;
      ball_pos  = '{x: coord_t'(300), y: AIR_Y};
      player1_x = coord_t'(200);
      player2_x = coord_t'(800);
      test_num  = 0;
      test_done = 1'b0;
      tb_errors = 0;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      repeat (2) @(negedge clk);
      end_test(0);
      for (int r = 1; r <= N_RALLIES; r++) begin
         run_rally(r);
         end_test(r);
      end
      if (!game_over) begin
         $display("game_over never rose after %0d rallies", N_RALLIES);
         tb_errors++;
      end
      repeat (2) @(negedge clk);
      total = chk_errors + tb_errors;
      $display("tests %0d, checks %0d, errors %0d", N_RALLIES + 1, chk_checks, total);
      if (total == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== volley_referee_top.f ====
+incdir+.
volley_geom_pkg.sv
volley_game_pkg.sv
contact_detect.sv
volley_judge.sv
volley_referee_top.sv
tb_volley_checker.sv
tb_volley_referee.sv

// ==== run_sim.sh ====
#!/bin/bash
# builds the referee testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_volley_referee \
   -f volley_referee_top.f -o tb_volley_referee > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_volley_referee > sim.log 2>&1
cat sim.log

# a fail line in the log or a log without the closing pass line counts as failure
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
